// ==== exu_pkg.sv ====
// datapath width and control field encodings for the execute stage
`default_nettype none

package exu_pkg;

  localparam int XLEN = 64;

  // alu control field
  typedef enum logic [4:0] {
    alu_add    = 5'd0,
    alu_sub    = 5'd1,
    alu_sll    = 5'd2,
    alu_slt    = 5'd3,
    alu_sltu   = 5'd4,
    alu_xor    = 5'd5,
    alu_srl    = 5'd6,
    alu_sra    = 5'd7,
    alu_or     = 5'd8,
    alu_and    = 5'd9,
    alu_copy_b = 5'd10  // lui
  } alu_op_e;

  // signedness of blt/bge comes from the alu op (sub or sltu)
  typedef enum logic [2:0] {
    br_none = 3'd0,
    br_jal  = 3'd1,
    br_jalr = 3'd2,
    br_beq  = 3'd4,
    br_bne  = 3'd5,
    br_blt  = 3'd6,
    br_bge  = 3'd7
  } branch_e;

  typedef enum logic [2:0] {
    mem_lb  = 3'd0,
    mem_lbu = 3'd1,
    mem_lh  = 3'd2,
    mem_lhu = 3'd3,
    mem_lw  = 3'd4,
    mem_lwu = 3'd5,
    mem_ld  = 3'd6
  } mem_op_e;

  typedef enum logic [1:0] {
    bsrc_rs2  = 2'd0,
    bsrc_imm  = 2'd1,
    bsrc_four = 2'd2
  } bsrc_e;

  // codes outside these three mean no special action
  typedef enum logic [3:0] {
    exctr_csrrw  = 4'd0,
    exctr_csrrs  = 4'd1,
    exctr_ebreak = 4'd14,
    exctr_none   = 4'd15
  } exctr_e;

endpackage

`default_nettype wire

// ==== exu_alu.sv ====
// 64-bit alu with word-op sign extension and zero/less flags
`timescale 1ns/1ps
`default_nettype none

module exu_alu (
  input  logic [exu_pkg::XLEN-1:0] i_src_a,
  input  logic [exu_pkg::XLEN-1:0] i_src_b,
  input  exu_pkg::alu_op_e         i_alu_ctr,
  input  logic                     i_word_cut,
  output logic [exu_pkg::XLEN-1:0] o_result,
  output logic                     o_zero,
  output logic                     o_less
);

  import exu_pkg::*;

  logic [XLEN-1:0] diff;
  logic [XLEN-1:0] raw;
  logic [XLEN-1:0] sra_src;
  logic [5:0]      shamt;
  logic            less_s;
  logic            less_u;

  assign diff   = i_src_a - i_src_b;
  assign less_s = $signed(i_src_a) < $signed(i_src_b);
  assign less_u = i_src_a < i_src_b;

  // word shifts only use 5 bits of amount
  assign shamt = i_word_cut ? {1'b0, i_src_b[4:0]} : i_src_b[5:0];

  // sraw shifts in bit 31, operand arrives zero extended
  assign sra_src = i_word_cut ? {{32{i_src_a[31]}}, i_src_a[31:0]} : i_src_a;

  always_comb begin
    case (i_alu_ctr)
      alu_add:    raw = i_src_a + i_src_b;
      alu_sub:    raw = diff;
      alu_sll:    raw = i_src_a << shamt;
      alu_slt:    raw = {{(XLEN-1){1'b0}}, less_s};
      alu_sltu:   raw = {{(XLEN-1){1'b0}}, less_u};
      alu_xor:    raw = i_src_a ^ i_src_b;
      alu_srl:    raw = i_src_a >> shamt;
      alu_sra:    raw = $signed(sra_src) >>> shamt;
      alu_or:     raw = i_src_a | i_src_b;
      alu_and:    raw = i_src_a & i_src_b;
      alu_copy_b: raw = i_src_b;
      default:    raw = '0;
    endcase
  end

  // word ops: keep low half, sign extend from bit 31
  assign o_result = i_word_cut ? {{32{raw[31]}}, raw[31:0]} : raw;

  assign o_zero = (diff == '0);
  assign o_less = (i_alu_ctr == alu_sltu) ? less_u : less_s; // unsigned only for sltu

endmodule

`default_nettype wire

// ==== exu_pc_jumper.sv ====
// next pc for sequential flow, jal, jalr and conditional branches
`timescale 1ns/1ps
`default_nettype none

module exu_pc_jumper (
  input  logic [exu_pkg::XLEN-1:0] i_rs1,
  input  logic [exu_pkg::XLEN-1:0] i_pc,
  input  logic [exu_pkg::XLEN-1:0] i_imm,
  input  exu_pkg::branch_e         i_branch,
  input  logic                     i_zero,
  input  logic                     i_less,
  output logic [exu_pkg::XLEN-1:0] o_nextpc
);

  import exu_pkg::*;

  logic [XLEN-1:0] pc_seq;
  logic [XLEN-1:0] pc_target;
  logic [XLEN-1:0] jalr_sum;

  assign pc_seq    = i_pc + 64'd4;
  assign pc_target = i_pc + i_imm;
  assign jalr_sum  = i_rs1 + i_imm;

  always_comb begin
    case (i_branch)
      br_jal:  o_nextpc = pc_target;
      br_jalr: o_nextpc = {jalr_sum[XLEN-1:1], 1'b0}; // bit 0 cleared
      br_beq:  o_nextpc = i_zero ? pc_target : pc_seq;
      br_bne:  o_nextpc = !i_zero ? pc_target : pc_seq;
      br_blt:  o_nextpc = i_less ? pc_target : pc_seq;
      br_bge:  o_nextpc = !i_less ? pc_target : pc_seq;
      default: o_nextpc = pc_seq;
    endcase
  end

  always_comb begin
    if (!$isunknown(i_branch)) begin
      assert (i_branch inside {br_none, br_jal, br_jalr, br_beq, br_bne, br_blt, br_bge})
        else $error("unused branch encoding %0d", i_branch);
    end
  end

endmodule

`default_nettype wire

// ==== exu_core.sv ====
// execute unit: operand select, alu, pc jumper, load extension, write-back and csr data
`timescale 1ns/1ps
`default_nettype none

module exu_core (
  input  logic [exu_pkg::XLEN-1:0] i_rs1,
  input  logic [exu_pkg::XLEN-1:0] i_rs2,
  input  logic [exu_pkg::XLEN-1:0] i_imm,
  input  logic [exu_pkg::XLEN-1:0] i_pc,
  input  logic [exu_pkg::XLEN-1:0] i_sysctr_pc,
  input  logic [exu_pkg::XLEN-1:0] i_rdata,
  input  logic [exu_pkg::XLEN-1:0] i_csrrdata,
  input  logic [exu_pkg::XLEN-1:0] i_zimm,
  input  logic                     i_alu_asrc,
  input  exu_pkg::bsrc_e           i_alu_bsrc,
  input  exu_pkg::alu_op_e         i_alu_ctr,
  input  logic                     i_word_cut,
  input  exu_pkg::branch_e         i_branch,
  input  exu_pkg::mem_op_e         i_mem_op,
  input  logic                     i_mem_to_reg,
  input  logic [3:0]               i_ex_ctr,
  input  logic                     i_is_invalid_inst,
  input  logic                     i_sel_csr,
  input  logic                     i_sel_zimm,
  input  logic                     i_sys_change_pc,
  output logic [exu_pkg::XLEN-1:0] o_alu_result,
  output logic [exu_pkg::XLEN-1:0] o_nextpc,
  output logic [exu_pkg::XLEN-1:0] o_gpr_wdata,
  output logic [exu_pkg::XLEN-1:0] o_csr_wdata,
  output logic                     o_ebreak,
  output logic                     o_invalid
);

  import exu_pkg::*;

  logic [XLEN-1:0] src1, src2, imm;
  logic [XLEN-1:0] src_a, src_b;
  logic [XLEN-1:0] branch_pc;
  logic [XLEN-1:0] load_data;
  logic [XLEN-1:0] csr_operand;
  logic            zero, less;

  // word ops see zero extended 32-bit operands
  assign src1 = i_word_cut ? {32'b0, i_rs1[31:0]} : i_rs1;
  assign src2 = i_word_cut ? {32'b0, i_rs2[31:0]} : i_rs2;
  assign imm  = i_word_cut ? {32'b0, i_imm[31:0]} : i_imm;

  assign src_a = i_alu_asrc ? i_pc : src1;

  always_comb begin
    case (i_alu_bsrc)
      bsrc_rs2:  src_b = src2;
      bsrc_imm:  src_b = imm;
      bsrc_four: src_b = 64'd4;
      default:   src_b = '0;
    endcase
  end

  exu_alu u_alu (
    .i_src_a   (src_a),
    .i_src_b   (src_b),
    .i_alu_ctr (i_alu_ctr),
    .i_word_cut(i_word_cut),
    .o_result  (o_alu_result),
    .o_zero    (zero),
    .o_less    (less)
  );

  exu_pc_jumper u_pc_jumper (
    .i_rs1   (i_rs1),
    .i_pc    (i_pc),
    .i_imm   (i_imm),
    .i_branch(i_branch),
    .i_zero  (zero),
    .i_less  (less),
    .o_nextpc(branch_pc)
  );

  assign o_nextpc = i_sys_change_pc ? i_sysctr_pc : branch_pc; // system redirect wins

  always_comb begin
    case (i_mem_op)
      mem_lb:  load_data = {{56{i_rdata[7]}}, i_rdata[7:0]};
      mem_lbu: load_data = {56'b0, i_rdata[7:0]};
      mem_lh:  load_data = {{48{i_rdata[15]}}, i_rdata[15:0]};
      mem_lhu: load_data = {48'b0, i_rdata[15:0]};
      mem_lw:  load_data = {{32{i_rdata[31]}}, i_rdata[31:0]};
      mem_lwu: load_data = {32'b0, i_rdata[31:0]};
      default: load_data = i_rdata; // ld
    endcase
  end

  // csr reads land in rd through rs2
  assign o_gpr_wdata = i_mem_to_reg ? load_data : (i_sel_csr ? i_rs2 : o_alu_result);

  assign csr_operand = i_sel_zimm ? i_zimm : i_rs1;

  always_comb begin
    case (i_ex_ctr)
      exctr_csrrw: o_csr_wdata = csr_operand;
      exctr_csrrs: o_csr_wdata = i_csrrdata | csr_operand;
      default:     o_csr_wdata = '0;
    endcase
  end

  assign o_ebreak  = (i_ex_ctr == exctr_ebreak);
  assign o_invalid = i_is_invalid_inst;

endmodule

`default_nettype wire

// ==== exu_top.sv ====
// req/ack wrapper around the execute core with sticky halt and abort flags
`timescale 1ns/1ps
`default_nettype none

module exu_top (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  logic                     i_req,
  output logic                     o_ack,
  input  logic [exu_pkg::XLEN-1:0] i_rs1,
  input  logic [exu_pkg::XLEN-1:0] i_rs2,
  input  logic [exu_pkg::XLEN-1:0] i_imm,
  input  logic [exu_pkg::XLEN-1:0] i_pc,
  input  logic [exu_pkg::XLEN-1:0] i_sysctr_pc,
  input  logic [exu_pkg::XLEN-1:0] i_rdata,
  input  logic [exu_pkg::XLEN-1:0] i_csrrdata,
  input  logic [exu_pkg::XLEN-1:0] i_zimm,
  input  logic                     i_alu_asrc,
  input  exu_pkg::bsrc_e           i_alu_bsrc,
  input  exu_pkg::alu_op_e         i_alu_ctr,
  input  logic                     i_word_cut,
  input  exu_pkg::branch_e         i_branch,
  input  exu_pkg::mem_op_e         i_mem_op,
  input  logic                     i_mem_to_reg,
  input  logic [3:0]               i_ex_ctr,
  input  logic                     i_is_invalid_inst,
  input  logic                     i_sel_csr,
  input  logic                     i_sel_zimm,
  input  logic                     i_sys_change_pc,
  output logic [exu_pkg::XLEN-1:0] o_alu_result,
  output logic [exu_pkg::XLEN-1:0] o_nextpc,
  output logic [exu_pkg::XLEN-1:0] o_gpr_wdata,
  output logic [exu_pkg::XLEN-1:0] o_csr_wdata,
  output logic                     o_halt,
  output logic                     o_abort
);

  import exu_pkg::*;

  localparam logic [1:0] st_idle    = 2'd0;
  localparam logic [1:0] st_compute = 2'd1;
  localparam logic [1:0] st_ack     = 2'd2;

  logic [1:0]      state;
  logic            capture;
  logic [XLEN-1:0] rs1_q, rs2_q, imm_q, pc_q, sysctr_pc_q, rdata_q, csrrdata_q, zimm_q;
  logic            alu_asrc_q, word_cut_q, mem_to_reg_q, invalid_q;
  logic            sel_csr_q, sel_zimm_q, sys_change_pc_q;
  bsrc_e           alu_bsrc_q;
  alu_op_e         alu_ctr_q;
  branch_e         branch_q;
  mem_op_e         mem_op_q;
  logic [3:0]      ex_ctr_q;
  logic [XLEN-1:0] alu_result_d, nextpc_d, gpr_wdata_d, csr_wdata_d;
  logic            ebreak_d, invalid_d;

  assign capture = (state == st_idle) && i_req && !o_ack;

  // operand capture
  always_ff @(posedge i_clk) begin
    if (capture) begin
      rs1_q       <= i_rs1;
      rs2_q       <= i_rs2;
      imm_q       <= i_imm;
      pc_q        <= i_pc;
      sysctr_pc_q <= i_sysctr_pc;
      rdata_q     <= i_rdata;
      csrrdata_q  <= i_csrrdata;
      zimm_q      <= i_zimm;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      alu_asrc_q      <= 1'b0;
      alu_bsrc_q      <= bsrc_rs2;
      alu_ctr_q       <= alu_add;
      word_cut_q      <= 1'b0;
      branch_q        <= br_none;
      mem_op_q        <= mem_ld;
      mem_to_reg_q    <= 1'b0;
      ex_ctr_q        <= exctr_none;
      invalid_q       <= 1'b0;
      sel_csr_q       <= 1'b0;
      sel_zimm_q      <= 1'b0;
      sys_change_pc_q <= 1'b0;
    end else if (capture) begin
      alu_asrc_q      <= i_alu_asrc;
      alu_bsrc_q      <= i_alu_bsrc;
      alu_ctr_q       <= i_alu_ctr;
      word_cut_q      <= i_word_cut;
      branch_q        <= i_branch;
      mem_op_q        <= i_mem_op;
      mem_to_reg_q    <= i_mem_to_reg;
      ex_ctr_q        <= i_ex_ctr;
      invalid_q       <= i_is_invalid_inst;
      sel_csr_q       <= i_sel_csr;
      sel_zimm_q      <= i_sel_zimm;
      sys_change_pc_q <= i_sys_change_pc;
    end
  end

  exu_core u_core (
    .i_rs1            (rs1_q),
    .i_rs2            (rs2_q),
    .i_imm            (imm_q),
    .i_pc             (pc_q),
    .i_sysctr_pc      (sysctr_pc_q),
    .i_rdata          (rdata_q),
    .i_csrrdata       (csrrdata_q),
    .i_zimm           (zimm_q),
    .i_alu_asrc       (alu_asrc_q),
    .i_alu_bsrc       (alu_bsrc_q),
    .i_alu_ctr        (alu_ctr_q),
    .i_word_cut       (word_cut_q),
    .i_branch         (branch_q),
    .i_mem_op         (mem_op_q),
    .i_mem_to_reg     (mem_to_reg_q),
    .i_ex_ctr         (ex_ctr_q),
    .i_is_invalid_inst(invalid_q),
    .i_sel_csr        (sel_csr_q),
    .i_sel_zimm       (sel_zimm_q),
    .i_sys_change_pc  (sys_change_pc_q),
    .o_alu_result     (alu_result_d),
    .o_nextpc         (nextpc_d),
    .o_gpr_wdata      (gpr_wdata_d),
    .o_csr_wdata      (csr_wdata_d),
    .o_ebreak         (ebreak_d),
    .o_invalid        (invalid_d)
  );

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state        <= st_idle;
      o_ack        <= 1'b0;
      o_halt       <= 1'b0;
      o_abort      <= 1'b0;
      o_alu_result <= '0;
      o_nextpc     <= '0;
      o_gpr_wdata  <= '0;
      o_csr_wdata  <= '0;
    end else begin
      case (state)
        st_idle: if (capture) state <= st_compute;
        st_compute: begin
          o_alu_result <= alu_result_d;
          o_nextpc     <= nextpc_d;
          o_gpr_wdata  <= gpr_wdata_d;
          o_csr_wdata  <= csr_wdata_d;
          o_ack        <= 1'b1;
          if (ebreak_d) o_halt <= 1'b1;   // sticky until reset
          if (invalid_d) o_abort <= 1'b1;
          state        <= st_ack;
        end
        st_ack: begin
          if (!i_req) begin
            o_ack <= 1'b0;
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  ack_held_a: assert property (@(posedge i_clk) disable iff (i_rst)
    o_ack && i_req |=> o_ack)
    else $error("ack dropped while req still high");

  ack_needs_req_a: assert property (@(posedge i_clk) disable iff (i_rst)
    $rose(o_ack) |-> $past(i_req))
    else $error("ack raised without a request");

  results_stable_a: assert property (@(posedge i_clk) disable iff (i_rst)
    o_ack |=> $stable({o_alu_result, o_nextpc, o_gpr_wdata, o_csr_wdata}))
    else $error("results changed while ack high");

endmodule

`default_nettype wire

// ==== tb_exu_ref.svh ====
// reference models for alu, next pc, load extension and csr data, plus the lfsr step
`ifndef TB_EXU_REF_SVH
`define TB_EXU_REF_SVH

  // 32-bit galois lfsr, output bit is bit 0
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  function automatic logic [63:0] model_alu(input alu_op_e op, input logic word,
                                            input logic [63:0] a, input logic [63:0] b);
    logic [63:0] r;
    logic [63:0] a_sx;
    int          sh;
    sh   = word ? int'(b[4:0]) : int'(b[5:0]);
    a_sx = word ? {{32{a[31]}}, a[31:0]} : a;
    case (op)
      alu_add:    r = a + b;
      alu_sub:    r = a - b;
      alu_sll:    r = a << sh;
      alu_slt:    r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      alu_sltu:   r = (a < b) ? 64'd1 : 64'd0;
      alu_xor:    r = a ^ b;
      alu_srl:    r = a >> sh;
      alu_sra:    r = $signed(a_sx) >>> sh;
      alu_or:     r = a | b;
      alu_and:    r = a & b;
      alu_copy_b: r = b;
      default:    r = 64'd0;
    endcase
    if (word) r = {{32{r[31]}}, r[31:0]};
    return r;
  endfunction

  function automatic logic [63:0] model_nextpc(input branch_e br, input alu_op_e op,
                                               input logic [63:0] a, input logic [63:0] b,
                                               input logic [63:0] rs1_v,
                                               input logic [63:0] pc_v,
                                               input logic [63:0] imm_v);
    logic take;
    logic lt;
    lt = (op == alu_sltu) ? (a < b) : ($signed(a) < $signed(b));
    case (br)
      br_jal:  return pc_v + imm_v;
      br_jalr: return (rs1_v + imm_v) & ~64'd1;
      br_beq:  take = (a == b);
      br_bne:  take = (a != b);
      br_blt:  take = lt;
      br_bge:  take = !lt;
      default: take = 1'b0;
    endcase
    return take ? pc_v + imm_v : pc_v + 64'd4;
  endfunction

  function automatic logic [63:0] model_load(input mem_op_e k, input logic [63:0] d);
    case (k)
      mem_lb:  return 64'($signed(d[7:0]));
      mem_lbu: return 64'(d[7:0]);
      mem_lh:  return 64'($signed(d[15:0]));
      mem_lhu: return 64'(d[15:0]);
      mem_lw:  return 64'($signed(d[31:0]));
      mem_lwu: return 64'(d[31:0]);
      default: return d;
    endcase
  endfunction

  function automatic logic [63:0] model_csr(input logic [3:0] ctr, input logic use_zimm,
                                            input logic [63:0] rs1_v,
                                            input logic [63:0] zimm_v,
                                            input logic [63:0] csr_v);
    logic [63:0] operand;
    operand = use_zimm ? zimm_v : rs1_v;
    if (ctr == exctr_csrrw) return operand;
    if (ctr == exctr_csrrs) return csr_v | operand;
    return 64'd0;
  endfunction

`endif

// ==== tb_exu_top.sv ====
// testbench for the execute stage: clock, reset, req/ack driver, checking assertions, report
`timescale 1ns/1ps
`default_nettype none

module tb_exu_top;

  import exu_pkg::*;

  localparam int clk_period   = 40;
  localparam int reset_cycles = 16;
  localparam int n_txn        = 61;
  localparam logic [63:0] minus_five = 64'hffff_ffff_ffff_fffb;
  localparam logic [63:0] three      = 64'd3;

  logic            clk, rst, req, ack;
  logic [XLEN-1:0] rs1, rs2, imm, pc, sysctr_pc, rdata, csrrdata, zimm;
  logic            alu_asrc, word_cut, mem_to_reg, is_invalid, sel_csr, sel_zimm;
  logic            sys_change_pc;
  bsrc_e           alu_bsrc;
  alu_op_e         alu_ctr;
  branch_e         branch;
  mem_op_e         mem_op;
  logic [3:0]      ex_ctr;
  logic [XLEN-1:0] alu_result, nextpc, gpr_wdata, csr_wdata;
  logic            halt, abort;
  logic [XLEN-1:0] exp_alu, exp_nextpc, exp_gpr, exp_csr;
  logic            exp_halt, exp_abort;
  logic [31:0]     lfsr_state;
  int              err_count, pass_count, fail_count;

  `include "tb_exu_ref.svh"

  exu_top dut_i (
    .i_clk(clk), .i_rst(rst), .i_req(req), .o_ack(ack),
    .i_rs1(rs1), .i_rs2(rs2), .i_imm(imm), .i_pc(pc), .i_sysctr_pc(sysctr_pc),
    .i_rdata(rdata), .i_csrrdata(csrrdata), .i_zimm(zimm),
    .i_alu_asrc(alu_asrc), .i_alu_bsrc(alu_bsrc), .i_alu_ctr(alu_ctr),
    .i_word_cut(word_cut), .i_branch(branch), .i_mem_op(mem_op),
    .i_mem_to_reg(mem_to_reg), .i_ex_ctr(ex_ctr), .i_is_invalid_inst(is_invalid),
    .i_sel_csr(sel_csr), .i_sel_zimm(sel_zimm), .i_sys_change_pc(sys_change_pc),
    .o_alu_result(alu_result), .o_nextpc(nextpc), .o_gpr_wdata(gpr_wdata),
    .o_csr_wdata(csr_wdata), .o_halt(halt), .o_abort(abort)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic void flag_value(input string msg);
    $display("** Error %0t ns: %s", $time, msg);
    err_count++;
  endfunction

  function automatic void flag_protocol(input string msg);
    $display("handshake problem at %0t ns: %s", $time, msg);
    err_count++;
  endfunction

  // results are compared whenever ack is high
  alu_check_a: assert property (@(posedge clk) disable iff (rst) ack |-> alu_result == exp_alu)
    else flag_value($sformatf("alu result %h, expected %h", $sampled(alu_result), exp_alu));
  nextpc_check_a: assert property (@(posedge clk) disable iff (rst) ack |-> nextpc == exp_nextpc)
    else flag_value($sformatf("next pc %h, expected %h", $sampled(nextpc), exp_nextpc));
  gpr_check_a: assert property (@(posedge clk) disable iff (rst) ack |-> gpr_wdata == exp_gpr)
    else flag_value($sformatf("gpr data %h, expected %h", $sampled(gpr_wdata), exp_gpr));
  csr_check_a: assert property (@(posedge clk) disable iff (rst) ack |-> csr_wdata == exp_csr)
    else flag_value($sformatf("csr data %h, expected %h", $sampled(csr_wdata), exp_csr));
  status_check_a: assert property (@(posedge clk) disable iff (rst)
    ack |-> halt == exp_halt && abort == exp_abort)
    else flag_value($sformatf("halt/abort %b%b, expected %b%b",
                              $sampled(halt), $sampled(abort), exp_halt, exp_abort));

  ack_timing_a: assert property (@(posedge clk) disable iff (rst)
    $rose(ack) == ($past(req, 2) && !$past(req, 3)))
    else flag_protocol("ack did not rise two edges after the request");
  ack_release_a: assert property (@(posedge clk) disable iff (rst) $fell(req) |=> $fell(ack))
    else flag_protocol("ack did not fall one edge after the request dropped");
  ack_hold_a: assert property (@(posedge clk) disable iff (rst)
    ack && req |=> ack && $stable(alu_result) && $stable(nextpc)
      && $stable(gpr_wdata) && $stable(csr_wdata))
    else flag_protocol("ack or results changed while the request was held");
  reset_values_a: assert property (@(posedge clk) $fell(rst) |->
    !ack && !halt && !abort && alu_result == '0 && nextpc == '0
      && gpr_wdata == '0 && csr_wdata == '0)
    else flag_value("outputs not cleared by reset");

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[62:0], lfsr_state[0]};
    end
    return r;
  endfunction

  task automatic randomize_data();
    logic [63:0] z;
    rs1       = rand_bits(64);
    rs2       = rand_bits(64);
    imm       = rand_bits(64);
    pc        = rand_bits(64);
    sysctr_pc = rand_bits(64);
    rdata     = rand_bits(64);
    csrrdata  = rand_bits(64);
    z         = rand_bits(5);
    zimm      = {59'b0, z[4:0]}; // 5-bit csr immediate
  endtask

  task automatic set_defaults();
    alu_asrc      = 1'b0;
    alu_bsrc      = bsrc_rs2;
    alu_ctr       = alu_add;
    word_cut      = 1'b0;
    branch        = br_none;
    mem_op        = mem_ld;
    mem_to_reg    = 1'b0;
    ex_ctr        = exctr_none;
    is_invalid    = 1'b0;
    sel_csr       = 1'b0;
    sel_zimm      = 1'b0;
    sys_change_pc = 1'b0;
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (reset_cycles) @(negedge clk);
    rst       = 1'b0;
    exp_halt  = 1'b0;
    exp_abort = 1'b0;
  endtask

  // called on a falling edge with all inputs set
  task automatic do_txn();
    logic [63:0] rs1_x, rs2_x, imm_x, op_a, op_b;
    int          extra;
    rs1_x = word_cut ? {32'b0, rs1[31:0]} : rs1;
    rs2_x = word_cut ? {32'b0, rs2[31:0]} : rs2;
    imm_x = word_cut ? {32'b0, imm[31:0]} : imm;
    op_a  = alu_asrc ? pc : rs1_x;
    case (alu_bsrc)
      bsrc_rs2: op_b = rs2_x;
      bsrc_imm: op_b = imm_x;
      default:  op_b = 64'd4;
    endcase
    exp_alu    = model_alu(alu_ctr, word_cut, op_a, op_b);
    exp_nextpc = sys_change_pc ? sysctr_pc
                               : model_nextpc(branch, alu_ctr, op_a, op_b, rs1, pc, imm);
    exp_gpr    = mem_to_reg ? model_load(mem_op, rdata) : (sel_csr ? rs2 : exp_alu);
    exp_csr    = model_csr(ex_ctr, sel_zimm, rs1, zimm, csrrdata);
    if (ex_ctr == exctr_ebreak) exp_halt = 1'b1;
    if (is_invalid) exp_abort = 1'b1;
    req = 1'b1;
    do @(negedge clk); while (!ack);
    extra = int'(rand_bits(2)); // back-pressure cycles
    repeat (extra) @(negedge clk);
    req = 1'b0;
    do @(negedge clk); while (ack);
  endtask

  function automatic void end_test(input string name, input int start);
    if (err_count == start) begin
      pass_count++;
      $display("%-10s ok", name);
    end else begin
      fail_count++;
      $display("%-10s %0d errors", name, err_count - start);
    end
  endfunction

  task automatic test_alu();
    int start;
    start = err_count;
    for (int k = 0; k < 11; k++) begin
      randomize_data();
      set_defaults();
      alu_ctr  = alu_op_e'(k);
      alu_asrc = k[0];
      alu_bsrc = bsrc_e'(k % 3);
      do_txn();
    end
    for (int k = 0; k < 11; k++) begin
      randomize_data();
      set_defaults();
      alu_ctr  = alu_op_e'(k);
      word_cut = 1'b1;
      alu_bsrc = k[0] ? bsrc_imm : bsrc_rs2;
      if (alu_ctr == alu_sra) rs1[31] = 1'b1; // negative word
      do_txn();
    end
    end_test("alu", start);
  endtask

  task automatic branch_case(input branch_e br, input alu_op_e op,
                             input logic [63:0] r1, input logic [63:0] r2);
    randomize_data();
    set_defaults();
    branch  = br;
    alu_ctr = op;
    rs1     = r1;
    rs2     = r2;
    if (br == br_jalr) begin
      rs1[0] = 1'b0;
      imm[0] = 1'b1;
    end
    do_txn();
  endtask

  task automatic test_branch();
    int          start;
    logic [63:0] v;
    start = err_count;
    v = rand_bits(64);
    branch_case(br_none, alu_sub, v, ~v);
    branch_case(br_jal, alu_add, v, v);
    branch_case(br_jalr, alu_add, v, v);
    branch_case(br_beq, alu_sub, v, v);
    branch_case(br_beq, alu_sub, v, v ^ 64'h10);
    branch_case(br_bne, alu_sub, v, v ^ 64'h10);
    branch_case(br_bne, alu_sub, v, v);
    branch_case(br_blt, alu_sub, minus_five, three);
    branch_case(br_blt, alu_sub, three, minus_five);
    branch_case(br_blt, alu_sltu, three, minus_five);
    branch_case(br_blt, alu_sltu, minus_five, three);
    branch_case(br_bge, alu_sub, three, minus_five);
    branch_case(br_bge, alu_sub, minus_five, three);
    branch_case(br_bge, alu_sltu, minus_five, three);
    branch_case(br_bge, alu_sltu, three, minus_five);
    randomize_data();
    set_defaults();
    branch        = br_jal;
    sys_change_pc = 1'b1;
    do_txn();
    end_test("branch", start);
  endtask

  task automatic test_writeback();
    int start;
    start = err_count;
    for (int k = 0; k < 7; k++) begin
      randomize_data();
      set_defaults();
      mem_op     = mem_op_e'(k);
      mem_to_reg = 1'b1;
      rdata      = rdata | 64'h8000_8080; // sign and zero extension differ
      do_txn();
    end
    randomize_data();
    set_defaults();
    sel_csr = 1'b1;
    do_txn();
    randomize_data();
    set_defaults();
    alu_ctr = alu_xor;
    do_txn();
    end_test("writeback", start);
  endtask

  task automatic csr_case(input logic [3:0] ctr, input logic use_zimm);
    randomize_data();
    set_defaults();
    ex_ctr   = ctr;
    sel_zimm = use_zimm;
    do_txn();
  endtask

  task automatic test_csr();
    int start;
    start = err_count;
    csr_case(exctr_csrrw, 1'b0);
    csr_case(exctr_csrrw, 1'b1);
    csr_case(exctr_csrrs, 1'b0);
    csr_case(exctr_csrrs, 1'b1);
    csr_case(4'd5, 1'b0);
    end_test("csr", start);
  endtask

  task automatic test_handshake();
    int start;
    start = err_count;
    repeat (4) begin
      randomize_data();
      set_defaults();
      alu_ctr = alu_op_e'(int'(rand_bits(4)) % 11);
      do_txn();
    end
    end_test("handshake", start);
  endtask

  task automatic test_status();
    int start;
    start = err_count;
    randomize_data();
    set_defaults();
    ex_ctr = exctr_ebreak;
    do_txn();
    randomize_data();
    set_defaults();
    is_invalid = 1'b1;
    do_txn();
    repeat (2) begin
      randomize_data();
      set_defaults();
      alu_ctr = alu_sub;
      do_txn();
    end
    apply_reset(); // halt and abort must clear here
    randomize_data();
    set_defaults();
    do_txn();
    end_test("status", start);
  endtask

  initial begin
    lfsr_state = 32'd28;
    err_count  = 0;
    pass_count = 0;
    fail_count = 0;
    req        = 1'b0;
    exp_alu    = '0;
    exp_nextpc = '0;
    exp_gpr    = '0;
    exp_csr    = '0;
    randomize_data();
    set_defaults();
    apply_reset();
    test_alu();
    test_branch();
    test_writeback();
    test_csr();
    test_handshake();
    test_status();
    repeat (2) @(negedge clk);
    $display("summary: %0d tests ok, %0d tests with errors", pass_count, fail_count);
    if (err_count == 0 && fail_count == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  // limit from transaction count plus both resets
  initial begin
    #(n_txn * 10 * clk_period + 2 * reset_cycles * clk_period);
    $display("watchdog: the run did not finish in time and was stopped");
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
exu_pkg.sv
exu_alu.sv
exu_pc_jumper.sv
exu_core.sv
exu_top.sv
tb_exu_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the execute stage testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_exu_top -f files.f -Mdir obj_dir -o tb_exu_top > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/tb_exu_top > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

grep -qx "test passed" sim.log
if [ $? -eq 0 ]; then
  echo "PASS"
  exit 0
fi

echo "FAIL, see sim.log"
exit 1
